// File: list.f
+incdir+include
design/div_pkg.sv
design/key_mux.sv
design/div_operand_prep.sv
design/div_restoring_core.sv
design/div_result_select.sv
design/div_unit.sv
test/div_unit_props.sv
test/div_unit_tb.sv

// File: test/div_unit_tb.sv
// ========================================
// divide unit testbench
// lcg stimulus, rv64 m reference model,
// start/ready driver, latency and hold
// checks, directed exception cases
// ========================================

`timescale 1ns/1ps
`default_nettype none

module div_unit_tb
  import div_pkg::*;
;

  localparam int          NUM_OPS   = 200;
  localparam int          LAT_LIMIT = 100;  // cycles before a wait gives up
  localparam logic [63:0] SEED      = 64'd77535;
  localparam xlen_t       MIN64     = 64'h8000_0000_0000_0000;

  logic    clk;
  logic    rst_n;
  logic    div_valid_i;
  div_op_e div_type_i;
  xlen_t   dividend_i;
  xlen_t   divisor_i;
  logic    result_ready_i;
  xlen_t   div_out_o;
  logic    div_busy_o;
  logic    result_ok_o;

  logic [63:0] lcg_state;
  div_op_e     all_ops [8] = '{OP_DIV, OP_DIVU, OP_REM, OP_REMU,
                               OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};

  div_unit div_unit_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .div_valid_i    (div_valid_i),
    .div_type_i     (div_type_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .result_ready_i (result_ready_i),
    .div_out_o      (div_out_o),
    .div_busy_o     (div_busy_o),
    .result_ok_o    (result_ok_o)
  );

  always #50 clk = ~clk;

  // ========================================
  // random numbers and stimulus shaping
  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
    return lcg_state[63:32];  // upper bits have the longer period
  endfunction

  function xlen_t rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = lcg_next();
    lo = lcg_next();
    return {hi, lo};
  endfunction

  // leans toward negative and word-sized values
  function xlen_t gen_operand();
    logic [31:0] sel;
    xlen_t       v;
    sel = lcg_next();
    v   = rand64();
    case (sel[2:0])
      3'd2, 3'd3: v[63] = 1'b1;
      3'd4:       v = 64'd0 - {48'h0, v[15:0]};
      3'd5:       v = {48'h0, v[15:0]};
      3'd6:       v = {32'hffff_ffff, 1'b1, v[30:0]};
      3'd7:       v = {v[63:32], 16'h0, v[15:0]};  // garbage upper half
      default:    v = v;
    endcase
    return v;
  endfunction

  function div_op_e pick_op();
    logic [31:0] sel;
    sel = lcg_next();
    return all_ops[sel[2:0]];
  endfunction

  // ========================================
  // reference model
  function automatic logic is_word(div_op_e op);
    return op inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  endfunction

  function automatic logic is_special(div_op_e op, xlen_t a, xlen_t b);
    logic zero;
    logic ovf;
    zero = is_word(op) ? (b[31:0] == 32'h0) : (b == 64'h0);
    ovf  = 1'b0;
    if (op inside {OP_DIV, OP_REM}) ovf = (a == MIN64) && (b == '1);
    if (op inside {OP_DIVW, OP_REMW}) ovf = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
    return zero || ovf;
  endfunction

  function automatic xlen_t model_result(div_op_e op, xlen_t a, xlen_t b);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic signed [63:0] sq;
    logic signed [63:0] sr;
    logic signed [31:0] wa;
    logic signed [31:0] wb;
    logic signed [31:0] wq;
    logic signed [31:0] wr;
    logic [31:0]        ua;
    logic [31:0]        ub;
    logic [31:0]        w;
    logic               wovf;
    xlen_t              r;
    sa   = a;
    sb   = b;
    wa   = a[31:0];
    wb   = b[31:0];
    ua   = a[31:0];
    ub   = b[31:0];
    // truncating signed results, only used when no special case applies
    sq   = sa / sb;
    sr   = sa % sb;
    wq   = wa / wb;
    wr   = wa % wb;
    w    = '0;
    r    = '0;
    wovf = (ua == 32'h8000_0000) && (ub == '1);
    case (op)
      OP_DIV:   r = (b == 0) ? '1 : (a == MIN64 && b == '1) ? a : sq;
      OP_DIVU:  r = (b == 0) ? '1 : a / b;
      OP_REM:   r = (b == 0) ? a : (a == MIN64 && b == '1) ? '0 : sr;
      OP_REMU:  r = (b == 0) ? a : a % b;
      OP_DIVW:  w = (ub == 0) ? '1 : wovf ? ua : wq;
      OP_DIVUW: w = (ub == 0) ? '1 : ua / ub;
      OP_REMW:  w = (ub == 0) ? ua : wovf ? '0 : wr;
      OP_REMUW: w = (ub == 0) ? ua : ua % ub;
      default:  r = '0;
    endcase
    if (is_word(op)) r = {{32{w[31]}}, w};  // bit 31 always extends
    return r;
  endfunction

  function automatic int expected_latency(div_op_e op, xlen_t a, xlen_t b);
    if (is_special(op, a, b)) return 0;  // ready right after the accepting edge
    return is_word(op) ? 33 : 65;
  endfunction

  // ========================================
  // checking
  task fail_and_stop();
    $display("Simulation failed");
    $fatal(1, "run stopped at first error");
  endtask

  task check_value(input logic [63:0] got, input logic [63:0] expected, input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      fail_and_stop();
    end
  endtask

  task drive_garbage(input logic valid);
    div_valid_i = valid;
    div_type_i  = pick_op();
    dividend_i  = gen_operand();
    divisor_i   = gen_operand();
  endtask

  // one division through the full handshake
  task run_op(input div_op_e op, input xlen_t a, input xlen_t b);
    xlen_t       expected;
    int          exp_lat;
    int          cycles;
    int          poke_at;
    int          delay;
    logic        poke_busy;
    logic        poke_finish;
    logic [31:0] r;
    string       tag;
    expected    = model_result(op, a, b);
    exp_lat     = expected_latency(op, a, b);
    r           = lcg_next();
    delay       = r[2:0];
    poke_busy   = (r[5:4] == 2'b00);
    poke_finish = (r[7:6] == 2'b00);
    poke_at     = (exp_lat > 0) ? (r[23:16] % exp_lat) : 0;
    tag         = $sformatf("%s a=%h b=%h", op.name(), a, b);

    @(negedge clk);
    check_value(result_ok_o, 1'b0, {tag, " result_ok before start"});
    check_value(div_busy_o, 1'b0, {tag, " busy before start"});
    div_valid_i    = 1'b1;
    div_type_i     = op;
    dividend_i     = a;
    divisor_i      = b;
    result_ready_i = 1'b0;
    #10;
    check_value(div_busy_o, !is_special(op, a, b), {tag, " busy in start cycle"});

    @(negedge clk);
    drive_garbage(1'b0);  // operands are held inside from here
    cycles = 0;
    while (!result_ok_o) begin
      if (cycles > LAT_LIMIT) begin
        $display("ERROR: no result within %0d cycles for %s", LAT_LIMIT, tag);
        fail_and_stop();
      end
      check_value(div_busy_o, 1'b1, {tag, " busy while dividing"});
      drive_garbage(poke_busy && (cycles == poke_at));
      @(negedge clk);
      cycles++;
    end
    div_valid_i = 1'b0;
    check_value(cycles, exp_lat, {tag, " latency"});
    check_value(div_out_o, expected, {tag, " result"});

    // back-pressure, result must sit still
    for (int i = 0; i < delay; i++) begin
      drive_garbage(poke_finish && (i == 0));
      @(negedge clk);
      check_value(result_ok_o, 1'b1, {tag, " result_ok held"});
      check_value(div_out_o, expected, {tag, " result held"});
    end
    div_valid_i    = 1'b0;
    result_ready_i = 1'b1;
    @(negedge clk);
    result_ready_i = 1'b0;
    check_value(result_ok_o, 1'b0, {tag, " result_ok after take"});
    check_value(div_busy_o, 1'b0, {tag, " no second division"});
  endtask

  // ========================================
  // main sequence
  initial begin
    xlen_t a;
    clk            = 1'b0;
    rst_n          = 1'b1;
    div_valid_i    = 1'b0;
    div_type_i     = OP_DIV;
    dividend_i     = '0;
    divisor_i      = '0;
    result_ready_i = 1'b0;
    lcg_state      = SEED;

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b0;

    // divide by zero, then word ops with only the upper half set
    foreach (all_ops[i]) run_op(all_ops[i], gen_operand(), '0);
    for (int i = 4; i < 8; i++) begin
      a = rand64();
      run_op(all_ops[i], gen_operand(), {a[63:32] | 32'h1, 32'h0});
    end

    // signed overflow
    run_op(OP_DIV, MIN64, '1);
    run_op(OP_REM, MIN64, '1);
    a = rand64();
    run_op(OP_DIVW, {a[63:32], 32'h8000_0000}, {a[31:0], 32'hffff_ffff});
    run_op(OP_REMW, {a[31:0], 32'h8000_0000}, {a[63:32], 32'hffff_ffff});

    for (int n = 0; n < NUM_OPS; n++) run_op(pick_op(), gen_operand(), gen_operand());

    @(negedge clk);
    if (div_unit_inst.u_props.failures != 0) begin
      $display("ERROR: %0d handshake assertion(s) failed",
               div_unit_inst.u_props.failures);
      $display("Simulation failed");
      $fatal(1, "assertion failures");
    end else begin
      $display("Simulation passed");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: test/div_unit_props.sv
// ========================================
// divider handshake properties
// bound to div_unit, checks the control
// outputs and the held result
// ========================================

`timescale 1ns/1ps
`default_nettype none

module div_unit_props
  import div_pkg::*;
(
  input wire logic  clk,
  input wire logic  rst_n,
  input wire logic  result_ok_o,
  input wire logic  div_busy_o,
  input wire logic  result_ready_i,
  input wire xlen_t div_out_o
);

  int failures = 0;  // read by the testbench at the end

  // finishing and stalling exclude each other
  a_ok_not_busy: assert property (@(posedge clk) disable iff (rst_n)
    !(result_ok_o && div_busy_o))
  else begin
    $error("result_ok_o and div_busy_o high together");
    failures++;
  end

  // held result under back-pressure
  a_result_held: assert property (@(posedge clk) disable iff (rst_n)
    (result_ok_o && !result_ready_i) |=> (result_ok_o && $stable(div_out_o)))
  else begin
    $error("result changed or dropped while not taken");
    failures++;
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst_n |=> (!result_ok_o && !div_busy_o))
  else begin
    $error("control outputs not low after reset");
    failures++;
  end

endmodule

bind div_unit div_unit_props u_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .result_ok_o    (result_ok_o),
  .div_busy_o     (div_busy_o),
  .result_ready_i (result_ready_i),
  .div_out_o      (div_out_o)
);

`default_nettype wire

// File: design/div_unit.sv
// ========================================
// rv64 m-extension divide unit
// operand prep, restoring core and
// result select behind a start/ready
// handshake
// ========================================

`timescale 1ns/1ps
`default_nettype none

module div_unit
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    div_valid_i,
  input  div_op_e div_type_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  input  logic    result_ready_i,
  output xlen_t   div_out_o,
  output logic    div_busy_o,
  output logic    result_ok_o
);

  xlen_t   dividend_mag;
  xlen_t   divisor_mag;
  logic    quot_neg;
  logic    rem_neg;
  logic    word_op;
  logic    exc;
  xlen_t   exc_value;
  div_op_e op_q;
  logic    quot_neg_q;
  logic    rem_neg_q;
  xlen_t   quotient;
  xlen_t   remainder;

  div_operand_prep u_prep (
    .op_i           (div_type_i),
    .dividend_i     (dividend_i),
    .divisor_i      (divisor_i),
    .dividend_mag_o (dividend_mag),
    .divisor_mag_o  (divisor_mag),
    .quot_neg_o     (quot_neg),
    .rem_neg_o      (rem_neg),
    .word_op_o      (word_op),
    .exc_o          (exc),
    .exc_value_o    (exc_value)
  );

  div_restoring_core u_core (
    .clk            (clk),
    .rst_n          (rst_n),
    .start_i        (div_valid_i),
    .op_i           (div_type_i),
    .dividend_mag_i (dividend_mag),
    .divisor_mag_i  (divisor_mag),
    .quot_neg_i     (quot_neg),
    .rem_neg_i      (rem_neg),
    .word_op_i      (word_op),
    .exc_i          (exc),
    .exc_value_i    (exc_value),
    .result_ready_i (result_ready_i),
    .op_q_o         (op_q),
    .quot_neg_q_o   (quot_neg_q),
    .rem_neg_q_o    (rem_neg_q),
    .quotient_o     (quotient),
    .remainder_o    (remainder),
    .busy_o         (div_busy_o),
    .done_o         (result_ok_o)
  );

  div_result_select u_select (
    .op_q_i       (op_q),
    .quot_neg_q_i (quot_neg_q),
    .rem_neg_q_i  (rem_neg_q),
    .quotient_i   (quotient),
    .remainder_i  (remainder),
    .result_o     (div_out_o)
  );

endmodule

`default_nettype wire

// File: design/div_result_select.sv
// ========================================
// divider result select
// re-signs quotient and remainder, sign
// extends word results and picks one by
// the registered operation code
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_result_select
  import div_pkg::*;
(
  input  div_op_e op_q_i,
  input  logic    quot_neg_q_i,
  input  logic    rem_neg_q_i,
  input  xlen_t   quotient_i,
  input  xlen_t   remainder_i,
  output xlen_t   result_o
);

  localparam int XL = `DIV_XLEN;
  localparam int WL = `DIV_WLEN;

  xlen_t quot_signed;
  xlen_t rem_signed;
  xlen_t quot_w;
  xlen_t quot_uw;
  xlen_t rem_w;
  xlen_t rem_uw;

  assign quot_signed = quot_neg_q_i ? -quotient_i : quotient_i;
  assign rem_signed  = rem_neg_q_i ? -remainder_i : remainder_i;

  // word results always sign extend bit 31
  assign quot_w  = {{(XL-WL){quot_signed[WL-1]}}, quot_signed[WL-1:0]};
  assign quot_uw = {{(XL-WL){quotient_i[WL-1]}}, quotient_i[WL-1:0]};
  assign rem_w   = {{(XL-WL){rem_signed[WL-1]}}, rem_signed[WL-1:0]};
  assign rem_uw  = {{(XL-WL){remainder_i[WL-1]}}, remainder_i[WL-1:0]};

  // OP_ERROR misses every key, raw quotient half is the default
  key_mux #(
    .NR_KEY   (8),
    .KEY_LEN  (`DIV_OP_W),
    .DATA_LEN (XL)
  ) u_mux (
    .key_i     (op_q_i),
    .default_i (quotient_i),
    .lut_i     ({OP_REM,   rem_signed,
                 OP_REMU,  remainder_i,
                 OP_REMUW, rem_uw,
                 OP_REMW,  rem_w,
                 OP_DIV,   quot_signed,
                 OP_DIVU,  quotient_i,
                 OP_DIVUW, quot_uw,
                 OP_DIVW,  quot_w}),
    .out_o     (result_o)
  );

endmodule

`default_nettype wire

// File: design/div_restoring_core.sv
// ========================================
// restoring divider core
// idle/iterate/finish controller with the
// remainder:quotient shift register, one
// quotient bit per cycle
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_restoring_core
  import div_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    start_i,
  input  div_op_e op_i,
  input  xlen_t   dividend_mag_i,
  input  xlen_t   divisor_mag_i,
  input  logic    quot_neg_i,
  input  logic    rem_neg_i,
  input  logic    word_op_i,
  input  logic    exc_i,
  input  xlen_t   exc_value_i,
  input  logic    result_ready_i,
  output div_op_e op_q_o,
  output logic    quot_neg_q_o,
  output logic    rem_neg_q_o,
  output xlen_t   quotient_o,
  output xlen_t   remainder_o,
  output logic    busy_o,
  output logic    done_o
);

  localparam int XL    = `DIV_XLEN;
  localparam int WL    = `DIV_WLEN;
  localparam int CNT_W = $clog2(XL + 1);

  div_state_e        state_q;
  div_state_e        state_d;
  logic [CNT_W-1:0]  count_q;
  logic [2*XL-1:0]   sreg_q;     // remainder high, quotient low
  logic [2*XL-1:0]   step;
  logic [XL:0]       trial;      // one extra bit for the borrow
  xlen_t             divisor_q;
  logic              accept;
  logic              iterate;

  assign accept  = (state_q == IDLE) && start_i;
  assign iterate = (state_q == DO_DIV) && (count_q != '0);

  // ========================================
  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (start_i) state_d = exc_i ? FINISH : DO_DIV;
      DO_DIV:  if (count_q == '0) state_d = FINISH;
      FINISH:  if (result_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  // control registers
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q      <= IDLE;
      count_q      <= '0;
      op_q_o       <= OP_ERROR;
      quot_neg_q_o <= 1'b0;
      rem_neg_q_o  <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        op_q_o       <= exc_i ? OP_ERROR : op_i;  // raw value passes on exceptions
        quot_neg_q_o <= quot_neg_i & ~exc_i;
        rem_neg_q_o  <= rem_neg_i & ~exc_i;
        count_q      <= word_op_i ? CNT_W'(WL) : CNT_W'(XL);
      end else if (iterate) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // ========================================
  // restoring step: shift, trial subtract, keep if not negative
  assign trial = sreg_q[2*XL-1:XL-1] - {1'b0, divisor_q};

  always_comb begin
    if (!trial[XL]) begin
      step = {trial[XL-1:0], sreg_q[XL-2:0], 1'b1};
    end else begin
      step = {sreg_q[2*XL-2:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      divisor_q <= divisor_mag_i;
      if (exc_i) begin
        sreg_q <= {{XL{1'b0}}, exc_value_i};
      end else if (word_op_i) begin
        // word dividend sits in the top half so 32 shifts finish it
        sreg_q <= {{XL{1'b0}}, dividend_mag_i[WL-1:0], {(XL-WL){1'b0}}};
      end else begin
        sreg_q <= {{XL{1'b0}}, dividend_mag_i};
      end
    end else if (iterate) begin
      sreg_q <= step;
    end
  end

  // ========================================
  // outputs
  assign quotient_o  = sreg_q[XL-1:0];
  assign remainder_o = sreg_q[2*XL-1:XL];

  assign busy_o = (accept && !exc_i) || (state_q == DO_DIV);  // stall request
  assign done_o = (state_q == FINISH);

endmodule

`default_nettype wire

// File: design/div_operand_prep.sv
// ========================================
// divider operand preparation
// word extension, magnitudes and signs,
// plus divide-by-zero / overflow detection
// with the architectural result for them
// ========================================

`timescale 1ns/1ps
`default_nettype none

`include "div_params.svh"

module div_operand_prep
  import div_pkg::*;
(
  input  div_op_e op_i,
  input  xlen_t   dividend_i,
  input  xlen_t   divisor_i,
  output xlen_t   dividend_mag_o,
  output xlen_t   divisor_mag_o,
  output logic    quot_neg_o,
  output logic    rem_neg_o,
  output logic    word_op_o,
  output logic    exc_o,
  output xlen_t   exc_value_o
);

  localparam int XL = `DIV_XLEN;
  localparam int WL = `DIV_WLEN;

  localparam logic [XL-1:0] XMIN = {1'b1, {(XL-1){1'b0}}};
  localparam logic [WL-1:0] WMIN = {1'b1, {(WL-1){1'b0}}};

  logic  signed_op;
  logic  div_op;
  logic  dividend_sgn;
  logic  divisor_sgn;
  logic  div_zero;
  logic  div_ovf;
  xlen_t dividend_sext;
  xlen_t divisor_sext;
  xlen_t dividend_ext;
  xlen_t divisor_ext;
  xlen_t exc_dividend;

  // ========================================
  // operation class
  assign word_op_o = op_i inside {OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW};
  assign signed_op = op_i inside {OP_DIV, OP_DIVW, OP_REM, OP_REMW};
  assign div_op    = op_i inside {OP_DIV, OP_DIVU, OP_DIVW, OP_DIVUW};

  // low halves, signed or unsigned as the op says
  assign dividend_sext = {{(XL-WL){dividend_i[WL-1]}}, dividend_i[WL-1:0]};
  assign divisor_sext  = {{(XL-WL){divisor_i[WL-1]}}, divisor_i[WL-1:0]};

  assign dividend_ext = !word_op_o ? dividend_i :
                        signed_op  ? dividend_sext : {{(XL-WL){1'b0}}, dividend_i[WL-1:0]};
  assign divisor_ext  = !word_op_o ? divisor_i :
                        signed_op  ? divisor_sext : {{(XL-WL){1'b0}}, divisor_i[WL-1:0]};

  // ========================================
  // magnitudes and result signs
  assign dividend_sgn = signed_op & dividend_ext[XL-1];
  assign divisor_sgn  = signed_op & divisor_ext[XL-1];

  assign dividend_mag_o = dividend_sgn ? -dividend_ext : dividend_ext;
  assign divisor_mag_o  = divisor_sgn ? -divisor_ext : divisor_ext;

  assign quot_neg_o = dividend_sgn ^ divisor_sgn;  // signs differ
  assign rem_neg_o  = dividend_sgn;                // follows the dividend

  // ========================================
  // exceptions
  assign div_zero = word_op_o ? ~|divisor_i[WL-1:0] : ~|divisor_i;

  // most negative / -1
  assign div_ovf = signed_op &
                   (word_op_o ? (dividend_i[WL-1:0] == WMIN) && (&divisor_i[WL-1:0]) :
                                (dividend_i == XMIN) && (&divisor_i));

  assign exc_o = div_zero | div_ovf;

  // rem returns the dividend sign-extended from bit 31 on word ops
  assign exc_dividend = word_op_o ? dividend_sext : dividend_i;

  always_comb begin
    if (div_zero) begin
      exc_value_o = div_op ? '1 : exc_dividend;
    end else if (div_ovf) begin
      exc_value_o = div_op ? exc_dividend : '0;
    end else begin
      exc_value_o = '0;
    end
  end

endmodule

`default_nettype wire

// File: design/key_mux.sv
// ========================================
// key/lookup multiplexer
// returns the data of the table entry whose
// key matches, else the default value
// ========================================

`timescale 1ns/1ps
`default_nettype none

module key_mux #(
  parameter int NR_KEY   = 2,
  parameter int KEY_LEN  = 1,
  parameter int DATA_LEN = 1
) (
  input  logic [KEY_LEN-1:0]                   key_i,
  input  logic [DATA_LEN-1:0]                  default_i,
  input  logic [NR_KEY*(KEY_LEN+DATA_LEN)-1:0] lut_i,  // {key, data} pairs
  output logic [DATA_LEN-1:0]                  out_o
);

  localparam int PAIR_LEN = KEY_LEN + DATA_LEN;

  always_comb begin
    out_o = default_i;
    for (int i = 0; i < NR_KEY; i++) begin
      if (lut_i[i*PAIR_LEN+DATA_LEN +: KEY_LEN] == key_i) begin
        out_o = lut_i[i*PAIR_LEN +: DATA_LEN];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/div_pkg.sv
// ========================================
// divider package
// operation codes, data word and the
// controller states of the divide unit
// ========================================

`default_nettype none

`include "div_params.svh"

package div_pkg;

  // one-hot operation code, zero marks a finished exception
  typedef enum logic [`DIV_OP_W-1:0] {
    OP_ERROR = 8'b0000_0000,
    OP_DIVW  = 8'b0000_0001,  // signed word div
    OP_DIVUW = 8'b0000_0010,  // unsigned word div
    OP_DIVU  = 8'b0000_0100,
    OP_DIV   = 8'b0000_1000,
    OP_REMW  = 8'b0001_0000,
    OP_REMUW = 8'b0010_0000,
    OP_REMU  = 8'b0100_0000,
    OP_REM   = 8'b1000_0000
  } div_op_e;

  typedef logic [`DIV_XLEN-1:0] xlen_t;

  // controller states
  typedef enum logic [1:0] {
    IDLE   = 2'b00,
    DO_DIV = 2'b01,  // one quotient bit per cycle
    FINISH = 2'b10   // result held until taken
  } div_state_e;

endpackage

`default_nettype wire

// File: include/div_params.svh
// ========================================
// divider parameters
// data width, word width and the width
// of the one-hot operation code
// ========================================

`ifndef DIV_PARAMS_SVH
`define DIV_PARAMS_SVH

// full register width of rv64
`define DIV_XLEN 64

// width of the *w operations
`define DIV_WLEN 32

// one bit per operation
`define DIV_OP_W 8

`endif
